// ==== src/ex_cfg.svh ====
/* Datapath width and shift-amount width macros */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Integer register width, RV32
`define XLEN 32

// Shift amount field, log2 of XLEN
`define SHAMT_W 5

`endif

// ==== src/rv32_isa_pkg.sv ====
/* Instruction word views, ALU function, operand select and branch funct3 types */
`default_nettype none

package rv32_isa_pkg;

	////////////////////////////////////////////////////////////
	// Instruction word layouts
	////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;            // Also the memory size
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;            // imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;            // imm[4:0]
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       of;                // imm[12], sign
			logic [5:0] s;                 // imm[10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;            // Branch condition
			logic [3:0] et;                // imm[4:1]
			logic       f;                 // imm[11]
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;              // imm[31:12]
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       of;                // imm[20], sign
			logic [9:0] et;                // imm[10:1]
			logic       s;                 // imm[11]
			logic [7:0] f;                 // imm[19:12]
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

	////////////////////////////////////////////////////////////
	// Control encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1, OPA_IS_NPC, OPA_IS_PC, OPA_IS_ZERO
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
		OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
	} opb_sel_e;

	// ISA funct3 codes, 010 and 011 reserved
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} br_func_e;

endpackage

`default_nettype wire

// ==== src/ex_pipe_pkg.sv ====
/* ID/EX and EX/MEM pipeline packet structs */
`default_nettype none

`include "ex_cfg.svh"

package ex_pipe_pkg;

	////////////////////////////////////////////////////////////
	// Decode to execute
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       npc;              // pc + 4
		rv32_isa_pkg::inst_t    inst;
		logic [`XLEN-1:0]       rs1_value;
		logic [`XLEN-1:0]       rs2_value;
		rv32_isa_pkg::opa_sel_e opa_select;
		rv32_isa_pkg::opb_sel_e opb_select;
		rv32_isa_pkg::alu_func_e alu_func;
		logic                   cond_branch;
		logic                   uncond_branch;    // JAL, JALR
		logic                   rd_mem;
		logic                   wr_mem;
		logic [4:0]             dest_reg_idx;
		logic                   halt;
		logic                   illegal;
	} id_ex_packet_t;

	////////////////////////////////////////////////////////////
	// Execute to memory
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [`XLEN-1:0] alu_result;             // Branch target on branches
		logic [`XLEN-1:0] npc;
		logic [`XLEN-1:0] rs2_value;              // Store data
		logic             take_branch;
		logic             rd_mem;
		logic             wr_mem;
		logic [2:0]       mem_size;               // funct3 of the load/store
		logic [4:0]       dest_reg_idx;
		logic             halt;
		logic             illegal;
	} ex_mem_packet_t;

endpackage

`default_nettype wire

// ==== src/ex_ops_if.sv ====
/* Operand and function bundle from operand select to the ALU and branch tester */
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

interface ex_ops_if (
	input logic clock,
	input logic reset
);
	logic                    valid;       // Operands belong to a live instruction
	logic [`XLEN-1:0]        opa;
	logic [`XLEN-1:0]        opb;
	logic [`XLEN-1:0]        rs1_value;   // Raw register values for compares
	logic [`XLEN-1:0]        rs2_value;
	rv32_isa_pkg::alu_func_e alu_func;
	rv32_isa_pkg::br_func_e  br_func;

	// Producer side
	modport sel (output valid, opa, opb, rs1_value, rs2_value, alu_func, br_func);

	// ALU sees muxed operands only
	modport alu_side (input clock, reset, valid, opa, opb, alu_func);

	// Branch tester sees register values only
	modport br_side (input rs1_value, rs2_value, br_func);

endinterface

`default_nettype wire

// ==== src/ex_operand_sel.sv ====
/* Operand A/B multiplexers and sign-extended immediate extraction */
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_operand_sel (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  ex_pipe_pkg::id_ex_packet_t pkt,
	input  wire logic                 valid,
	ex_ops_if.sel                     ops
);
	// Markers seen on the bus when a select is bad
	localparam logic [`XLEN-1:0] OPA_MARK = `XLEN'hbad0_a5e1;
	localparam logic [`XLEN-1:0] OPB_MARK = `XLEN'hbad0_b5e1;

	logic [`XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

	////////////////////////////////////////////////////////////
	// Immediates
	////////////////////////////////////////////////////////////
	assign i_imm = {{(`XLEN-12){pkt.inst.i.imm[11]}}, pkt.inst.i.imm};
	assign s_imm = {{(`XLEN-12){pkt.inst.s.imm_hi[6]}}, pkt.inst.s.imm_hi, pkt.inst.s.imm_lo};
	assign b_imm = {{(`XLEN-12){pkt.inst.b.of}}, pkt.inst.b.f, pkt.inst.b.s,
		pkt.inst.b.et, 1'b0};                                 // Halfword aligned
	assign u_imm = {pkt.inst.u.imm, 12'b0};                   // Upper 20, low zero
	assign j_imm = {{(`XLEN-20){pkt.inst.j.of}}, pkt.inst.j.f, pkt.inst.j.s,
		pkt.inst.j.et, 1'b0};

	////////////////////////////////////////////////////////////
	// Operand muxes
	////////////////////////////////////////////////////////////
	always_comb begin
		case (pkt.opa_select)
			rv32_isa_pkg::OPA_IS_RS1:  ops.opa = pkt.rs1_value;
			rv32_isa_pkg::OPA_IS_NPC:  ops.opa = pkt.npc;        // Link address
			rv32_isa_pkg::OPA_IS_PC:   ops.opa = pkt.pc;         // AUIPC, branch target
			rv32_isa_pkg::OPA_IS_ZERO: ops.opa = '0;             // LUI
			default:                   ops.opa = OPA_MARK;
		endcase
	end

	always_comb begin
		case (pkt.opb_select)
			rv32_isa_pkg::OPB_IS_RS2:   ops.opb = pkt.rs2_value;
			rv32_isa_pkg::OPB_IS_I_IMM: ops.opb = i_imm;
			rv32_isa_pkg::OPB_IS_S_IMM: ops.opb = s_imm;
			rv32_isa_pkg::OPB_IS_B_IMM: ops.opb = b_imm;
			rv32_isa_pkg::OPB_IS_U_IMM: ops.opb = u_imm;
			rv32_isa_pkg::OPB_IS_J_IMM: ops.opb = j_imm;
			default:                    ops.opb = OPB_MARK;  // Codes 6 and 7
		endcase
	end

	// Compare side and function codes
	assign ops.valid     = valid;
	assign ops.rs1_value = pkt.rs1_value;
	assign ops.rs2_value = pkt.rs2_value;
	assign ops.alu_func  = pkt.alu_func;
	assign ops.br_func   = rv32_isa_pkg::br_func_e'(pkt.inst.b.funct3);

	// Decoder must never hand over a bad select with a live packet
	a_opa_known: assert property (@(posedge clock) disable iff (reset)
		valid |-> !$isunknown(pkt.opa_select))
		else $error("opa_select unknown on valid packet");

	a_opb_range: assert property (@(posedge clock) disable iff (reset)
		valid |-> (pkt.opb_select inside {[rv32_isa_pkg::OPB_IS_RS2:rv32_isa_pkg::OPB_IS_J_IMM]}))
		else $error("opb_select out of range on valid packet");

endmodule

`default_nettype wire

// ==== src/alu.sv ====
/* Integer and M-extension multiply ALU */
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module alu (
	ex_ops_if.alu_side             ops,
	output logic [`XLEN-1:0]       result
);
	logic [`SHAMT_W-1:0] shamt;
	logic                lt_s, lt_u;

	// Operands widened to 2*XLEN, extension carries the sign
	logic [2*`XLEN-1:0] opa_sx, opa_zx, opb_sx, opb_zx;
	logic [2*`XLEN-1:0] prod_ss, prod_su, prod_uu;

	assign shamt = ops.opb[`SHAMT_W-1:0];                     // Shift mod XLEN
	assign lt_s  = $signed(ops.opa) < $signed(ops.opb);
	assign lt_u  = ops.opa < ops.opb;

	////////////////////////////////////////////////////////////
	// Multiplier products
	////////////////////////////////////////////////////////////
	assign opa_sx = {{`XLEN{ops.opa[`XLEN-1]}}, ops.opa};
	assign opb_sx = {{`XLEN{ops.opb[`XLEN-1]}}, ops.opb};
	assign opa_zx = {{`XLEN{1'b0}}, ops.opa};
	assign opb_zx = {{`XLEN{1'b0}}, ops.opb};

	assign prod_ss = opa_sx * opb_sx;     // Low 2*XLEN bits exact
	assign prod_su = opa_sx * opb_zx;     // Signed A times unsigned B
	assign prod_uu = opa_zx * opb_zx;

	////////////////////////////////////////////////////////////
	// Function select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ops.alu_func)
			rv32_isa_pkg::ALU_ADD:    result = ops.opa + ops.opb;
			rv32_isa_pkg::ALU_SUB:    result = ops.opa - ops.opb;
			rv32_isa_pkg::ALU_AND:    result = ops.opa & ops.opb;
			rv32_isa_pkg::ALU_OR:     result = ops.opa | ops.opb;
			rv32_isa_pkg::ALU_XOR:    result = ops.opa ^ ops.opb;
			rv32_isa_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_s};
			rv32_isa_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_u};
			rv32_isa_pkg::ALU_SLL:    result = ops.opa << shamt;
			rv32_isa_pkg::ALU_SRL:    result = ops.opa >> shamt;
			rv32_isa_pkg::ALU_SRA:    result = $signed(ops.opa) >>> shamt;  // Sign fill
			rv32_isa_pkg::ALU_MUL:    result = prod_ss[`XLEN-1:0];
			rv32_isa_pkg::ALU_MULH:   result = prod_ss[2*`XLEN-1:`XLEN];
			rv32_isa_pkg::ALU_MULHSU: result = prod_su[2*`XLEN-1:`XLEN];
			rv32_isa_pkg::ALU_MULHU:  result = prod_uu[2*`XLEN-1:`XLEN];
			default:                  result = `XLEN'hbad0_a1f0;  // Codes 14, 15
		endcase
	end

	// Function code must be clean whenever a live instruction uses the ALU
	a_func_known: assert property (@(posedge ops.clock) disable iff (ops.reset)
		ops.valid |-> !$isunknown(ops.alu_func))
		else $error("alu_func unknown on valid instruction");

endmodule

`default_nettype wire

// ==== src/brcond.sv ====
/* Branch condition evaluator */
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module brcond (
	ex_ops_if.br_side ops,
	output logic      cond       // 1 when the branch condition holds
);
	logic signed [`XLEN-1:0] rs1_s, rs2_s;

	assign rs1_s = ops.rs1_value;
	assign rs2_s = ops.rs2_value;

	always_comb begin
		case (ops.br_func)
			rv32_isa_pkg::BR_BEQ:  cond = ops.rs1_value == ops.rs2_value;
			rv32_isa_pkg::BR_BNE:  cond = ops.rs1_value != ops.rs2_value;
			rv32_isa_pkg::BR_BLT:  cond = rs1_s <  rs2_s;              // Signed
			rv32_isa_pkg::BR_BGE:  cond = rs1_s >= rs2_s;
			rv32_isa_pkg::BR_BLTU: cond = ops.rs1_value <  ops.rs2_value;
			rv32_isa_pkg::BR_BGEU: cond = ops.rs1_value >= ops.rs2_value;
			default:               cond = 1'b0;                      // Reserved funct3
		endcase
	end

endmodule

`default_nettype wire

// ==== src/pipe_reg.sv ====
/* Stallable pipeline register with valid bit and typed payload */
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic stall,       // Hold everything while high
	input  wire logic valid_d,
	input  payload_t  data_d,
	output logic      valid_q,
	output payload_t  data_q
);

	// Valid bit cleared by reset
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= valid_d;
		end
	end

	// Payload loads on every unstalled edge
	always_ff @(posedge clock) begin
		if (!stall) begin
			data_q <= data_d;
		end
	end

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
/* Execute stage top: ID/EX and EX/MEM registers, operand select, ALU and branch tester */
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     stall,         // Global freeze
	input  wire logic                     id_valid,
	input  wire logic [`XLEN-1:0]         pc,
	input  wire logic [`XLEN-1:0]         npc,
	input  rv32_isa_pkg::inst_t           inst,
	input  wire logic [`XLEN-1:0]         rs1_value,
	input  wire logic [`XLEN-1:0]         rs2_value,
	input  rv32_isa_pkg::opa_sel_e        opa_select,
	input  rv32_isa_pkg::opb_sel_e        opb_select,
	input  rv32_isa_pkg::alu_func_e       alu_func,
	input  wire logic                     cond_branch,
	input  wire logic                     uncond_branch,
	input  wire logic                     rd_mem,
	input  wire logic                     wr_mem,
	input  wire logic [4:0]               dest_reg_idx,
	input  wire logic                     halt,
	input  wire logic                     illegal,
	output logic                          ex_valid,
	output logic [`XLEN-1:0]              ex_alu_result,
	output logic [`XLEN-1:0]              ex_npc,
	output logic [`XLEN-1:0]              ex_rs2_value,
	output logic                          ex_take_branch,
	output logic                          ex_rd_mem,
	output logic                          ex_wr_mem,
	output logic [2:0]                    ex_mem_size,
	output logic [4:0]                    ex_dest_reg_idx,
	output logic                          ex_halt,
	output logic                          ex_illegal
);
	ex_pipe_pkg::id_ex_packet_t  id_ex_d, id_ex_q;
	ex_pipe_pkg::ex_mem_packet_t ex_mem_d, ex_mem_q;
	logic                        id_ex_valid;
	logic [`XLEN-1:0]            alu_result;
	logic                        br_cond;

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////
	always_comb begin
		id_ex_d.pc            = pc;
		id_ex_d.npc           = npc;
		id_ex_d.inst          = inst;
		id_ex_d.rs1_value     = rs1_value;
		id_ex_d.rs2_value     = rs2_value;
		id_ex_d.opa_select    = opa_select;
		id_ex_d.opb_select    = opb_select;
		id_ex_d.alu_func      = alu_func;
		id_ex_d.cond_branch   = cond_branch;
		id_ex_d.uncond_branch = uncond_branch;
		id_ex_d.rd_mem        = rd_mem;
		id_ex_d.wr_mem        = wr_mem;
		id_ex_d.dest_reg_idx  = dest_reg_idx;
		id_ex_d.halt          = halt;
		id_ex_d.illegal       = illegal;
	end

	pipe_reg #(.payload_t(ex_pipe_pkg::id_ex_packet_t)) u_id_ex (
		.clock   (clock),
		.reset   (reset),
		.stall   (stall),
		.valid_d (id_valid),
		.data_d  (id_ex_d),
		.valid_q (id_ex_valid),
		.data_q  (id_ex_q)
	);

	////////////////////////////////////////////////////////////
	// Operands and the two datapaths
	////////////////////////////////////////////////////////////
	ex_ops_if ops (.clock(clock), .reset(reset));

	ex_operand_sel u_operand_sel (
		.clock (clock),
		.reset (reset),
		.pkt   (id_ex_q),
		.valid (id_ex_valid),
		.ops   (ops.sel)
	);

	alu u_alu (
		.ops    (ops.alu_side),
		.result (alu_result)
	);

	brcond u_brcond (
		.ops  (ops.br_side),
		.cond (br_cond)
	);

	// EX/MEM packet, target stays in alu_result
	always_comb begin
		ex_mem_d.alu_result   = alu_result;
		ex_mem_d.npc          = id_ex_q.npc;
		ex_mem_d.rs2_value    = id_ex_q.rs2_value;
		ex_mem_d.take_branch  = id_ex_q.uncond_branch | (id_ex_q.cond_branch & br_cond);
		ex_mem_d.rd_mem       = id_ex_q.rd_mem;
		ex_mem_d.wr_mem       = id_ex_q.wr_mem;
		ex_mem_d.mem_size     = id_ex_q.inst.r.funct3;   // Byte, half, word
		ex_mem_d.dest_reg_idx = id_ex_q.dest_reg_idx;
		ex_mem_d.halt         = id_ex_q.halt;
		ex_mem_d.illegal      = id_ex_q.illegal;
	end

	////////////////////////////////////////////////////////////
	// EX/MEM register and output unpack
	////////////////////////////////////////////////////////////
	pipe_reg #(.payload_t(ex_pipe_pkg::ex_mem_packet_t)) u_ex_mem (
		.clock   (clock),
		.reset   (reset),
		.stall   (stall),
		.valid_d (id_ex_valid),
		.data_d  (ex_mem_d),
		.valid_q (ex_valid),
		.data_q  (ex_mem_q)
	);

	assign ex_alu_result   = ex_mem_q.alu_result;
	assign ex_npc          = ex_mem_q.npc;
	assign ex_rs2_value    = ex_mem_q.rs2_value;
	assign ex_take_branch  = ex_mem_q.take_branch;
	assign ex_rd_mem       = ex_mem_q.rd_mem;
	assign ex_wr_mem       = ex_mem_q.wr_mem;
	assign ex_mem_size     = ex_mem_q.mem_size;
	assign ex_dest_reg_idx = ex_mem_q.dest_reg_idx;
	assign ex_halt         = ex_mem_q.halt;
	assign ex_illegal      = ex_mem_q.illegal;

endmodule

`default_nettype wire

// ==== verif/ex_stage_tb.sv ====
/* Execute stage testbench with LFSR stimulus, reference model,
   stall and reset checks, watchdog and per-test report */
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage_tb;

	localparam int CLK_NS    = 4;
	localparam int N_ALU     = 14 * 12;          // Each function a dozen times
	localparam int N_SEL     = 24 * 4;           // Every opa/opb pair four times
	localparam int N_BR      = 6 * 20;
	localparam int N_PASS    = 150;
	localparam int N_STALL   = 200;
	localparam int N_RESET   = 40;
	localparam int TOTAL_TXN = N_ALU + N_SEL + N_BR + N_PASS + N_STALL + N_RESET;
	localparam int WORST_CYC = 8;                // Stall runs capped at 3 plus idle gaps
	localparam longint WATCHDOG_NS = longint'(TOTAL_TXN * WORST_CYC + 600) * CLK_NS;

	localparam int MODE_ALU = 0;
	localparam int MODE_SEL = 1;
	localparam int MODE_BR  = 2;
	localparam int MODE_MIX = 3;

	// ISA branch funct3 codes
	localparam logic [2:0] BR_CODES [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	logic                    clock = 1'b0;
	logic                    reset, stall, id_valid;
	logic [`XLEN-1:0]        pc, npc, rs1_value, rs2_value;
	rv32_isa_pkg::inst_t     inst;
	rv32_isa_pkg::opa_sel_e  opa_select;
	rv32_isa_pkg::opb_sel_e  opb_select;
	rv32_isa_pkg::alu_func_e alu_func;
	logic                    cond_branch, uncond_branch, rd_mem, wr_mem, halt, illegal;
	logic [4:0]              dest_reg_idx;
	logic                    ex_valid, ex_take_branch, ex_rd_mem, ex_wr_mem, ex_halt, ex_illegal;
	logic [`XLEN-1:0]        ex_alu_result, ex_npc, ex_rs2_value;
	logic [2:0]              ex_mem_size;
	logic [4:0]              ex_dest_reg_idx;

	ex_pipe_pkg::ex_mem_packet_t exp_q[$];      // Model results in issue order
	logic [31:0]  lfsr = 32'h3e76_c3e9;
	logic [109:0] held_snap;                     // Outputs seen at the last check
	logic         edge_stall, edge_reset;        // Inputs at the coming rising edge
	int           stall_run, sent, errors, checks, popped;

	ex_stage i_dut (.*);

	always #(CLK_NS / 2) clock = ~clock;

	////////////////////////////////////////////////////////////
	// Random numbers
	////////////////////////////////////////////////////////////
	// Fibonacci with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          k;
		r = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};                // One step per bit
		end
		return r;
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = rand_bits(1);
		return r[0];
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic ex_pipe_pkg::ex_mem_packet_t predict();
		ex_pipe_pkg::ex_mem_packet_t e;
		logic [31:0] w, a, b, r;
		logic [63:0] p;
		longint      sa;
		logic        c;
		w = inst;
		case (opa_select)
			rv32_isa_pkg::OPA_IS_RS1: a = rs1_value;
			rv32_isa_pkg::OPA_IS_NPC: a = npc;
			rv32_isa_pkg::OPA_IS_PC:  a = pc;
			default:                  a = 32'h0;
		endcase
		case (opb_select)
			rv32_isa_pkg::OPB_IS_I_IMM: b = {{20{w[31]}}, w[31:20]};
			rv32_isa_pkg::OPB_IS_S_IMM: b = {{20{w[31]}}, w[31:25], w[11:7]};
			rv32_isa_pkg::OPB_IS_B_IMM: b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			rv32_isa_pkg::OPB_IS_U_IMM: b = {w[31:12], 12'h000};
			rv32_isa_pkg::OPB_IS_J_IMM: b = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default:                    b = rs2_value;       // RS2
		endcase
		sa = longint'($signed(a));
		p  = '0;
		case (alu_func)
			rv32_isa_pkg::ALU_ADD:  r = a + b;
			rv32_isa_pkg::ALU_SUB:  r = a - b;
			rv32_isa_pkg::ALU_AND:  r = a & b;
			rv32_isa_pkg::ALU_OR:   r = a | b;
			rv32_isa_pkg::ALU_XOR:  r = a ^ b;
			rv32_isa_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv32_isa_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			rv32_isa_pkg::ALU_SLL:  r = a << b[4:0];
			rv32_isa_pkg::ALU_SRL:  r = a >> b[4:0];
			rv32_isa_pkg::ALU_SRA:  r = $signed(a) >>> b[4:0];
			rv32_isa_pkg::ALU_MUL:  r = a * b;
			rv32_isa_pkg::ALU_MULH: begin
				p = sa * longint'($signed(b));
				r = p[63:32];
			end
			rv32_isa_pkg::ALU_MULHSU: begin
				p = sa * longint'({32'h0, b});              // B stays positive
				r = p[63:32];
			end
			rv32_isa_pkg::ALU_MULHU: begin
				p = {32'h0, a} * {32'h0, b};
				r = p[63:32];
			end
			default: r = 32'hx;
		endcase
		case (w[14:12])
			3'b000:  c = (rs1_value == rs2_value);
			3'b001:  c = (rs1_value != rs2_value);
			3'b100:  c = ($signed(rs1_value) < $signed(rs2_value));
			3'b101:  c = ($signed(rs1_value) >= $signed(rs2_value));
			3'b110:  c = (rs1_value < rs2_value);
			3'b111:  c = (rs1_value >= rs2_value);
			default: c = 1'b0;
		endcase
		e.alu_result   = r;
		e.npc          = npc;
		e.rs2_value    = rs2_value;
		e.take_branch  = uncond_branch || (cond_branch && c);
		e.rd_mem       = rd_mem;
		e.wr_mem       = wr_mem;
		e.mem_size     = w[14:12];
		e.dest_reg_idx = dest_reg_idx;
		e.halt         = halt;
		e.illegal      = illegal;
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Called at the falling edge with outputs settled
	task automatic sample_outputs();
		ex_pipe_pkg::ex_mem_packet_t e;
		logic [109:0] now_snap;
		now_snap = {ex_valid, ex_alu_result, ex_npc, ex_rs2_value, ex_take_branch, ex_rd_mem,
			ex_wr_mem, ex_mem_size, ex_dest_reg_idx, ex_halt, ex_illegal};
		if (edge_reset) begin
			check_value("ex_valid", 32'(ex_valid), 32'd0);
		end else if (edge_stall) begin
			checks++;
			if (now_snap !== held_snap) begin
				errors++;
				$display("** Error at %0t ns: outputs changed while stall was high", $time);
			end
		end else if (ex_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Instruction appeared at %0t ns with none in flight", $time);
			end else begin
				e = exp_q.pop_front();
				popped++;
				check_value("alu_result", ex_alu_result, e.alu_result);
				check_value("npc", ex_npc, e.npc);
				check_value("rs2_value", ex_rs2_value, e.rs2_value);
				check_value("take_branch", 32'(ex_take_branch), 32'(e.take_branch));
				check_value("rd_mem", 32'(ex_rd_mem), 32'(e.rd_mem));
				check_value("wr_mem", 32'(ex_wr_mem), 32'(e.wr_mem));
				check_value("mem_size", 32'(ex_mem_size), 32'(e.mem_size));
				check_value("dest_reg_idx", 32'(ex_dest_reg_idx), 32'(e.dest_reg_idx));
				check_value("halt", 32'(ex_halt), 32'(e.halt));
				check_value("illegal", 32'(ex_illegal), 32'(e.illegal));
			end
		end
		held_snap = now_snap;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic new_instruction(input int mode, input int k);
		pc            = rand_bits(30) << 2;
		npc           = pc + 32'd4;
		inst          = rand_bits(32);
		rs1_value     = rand_bits(32);
		rs2_value     = rand_bits(32);
		rd_mem        = rand_bit();
		wr_mem        = rand_bit();
		dest_reg_idx  = 5'(rand_bits(5));
		halt          = rand_bit();
		illegal       = rand_bit();
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		case (mode)
			MODE_ALU: begin
				opa_select = rv32_isa_pkg::OPA_IS_RS1;
				opb_select = rv32_isa_pkg::OPB_IS_RS2;
				alu_func   = rv32_isa_pkg::alu_func_e'(k % 14);
			end
			MODE_SEL: begin
				opa_select = rv32_isa_pkg::opa_sel_e'(k % 4);
				opb_select = rv32_isa_pkg::opb_sel_e'((k / 4) % 6);
				alu_func   = rv32_isa_pkg::ALU_ADD;
			end
			MODE_BR: begin
				opa_select    = rv32_isa_pkg::OPA_IS_PC;          // Target pc + B imm
				opb_select    = rv32_isa_pkg::OPB_IS_B_IMM;
				alu_func      = rv32_isa_pkg::ALU_ADD;
				inst.b.funct3 = BR_CODES[k % 6];
				cond_branch   = rand_bit();
				uncond_branch = rand_bit();
				if (rand_bits(2) == 0)
					rs2_value = rs1_value;                        // Equal operands now and then
			end
			default: begin
				opa_select    = rv32_isa_pkg::opa_sel_e'(rand_bits(2));
				opb_select    = rv32_isa_pkg::opb_sel_e'(rand_bits(3) % 6);
				alu_func      = rv32_isa_pkg::alu_func_e'(rand_bits(4) % 14);
				cond_branch   = rand_bit();
				uncond_branch = rand_bit();
			end
		endcase
	endtask

	// Check at one falling edge and drive for the next rising edge
	task automatic step(input int mode, input bit stall_on, input bit gaps);
		@(negedge clock);
		sample_outputs();
		if (!stall) begin                                   // Held while stalled
			new_instruction(mode, sent);
			id_valid = gaps ? (rand_bits(3) != 0) : 1'b1;
		end
		stall     = stall_on && (stall_run < 3) && (rand_bits(3) < 3);
		stall_run = stall ? stall_run + 1 : 0;
		if (!stall && id_valid) begin
			exp_q.push_back(predict());
			sent++;
		end
		edge_stall = stall;
		edge_reset = reset;
	endtask

	task automatic idle_cycle();
		@(negedge clock);
		sample_outputs();
		id_valid   = 1'b0;
		stall      = 1'b0;
		stall_run  = 0;
		edge_stall = 1'b0;
		edge_reset = reset;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 8) begin
			idle_cycle();
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d instructions never reached the outputs by %0t ns", exp_q.size(), $time);
			exp_q.delete();
		end
		idle_cycle();                                       // Catch duplicates
		idle_cycle();
	endtask

	task automatic pulse_reset(input int cycles);
		@(negedge clock);
		sample_outputs();
		reset      = 1'b1;
		id_valid   = 1'b0;
		stall      = 1'b1;                                  // Only reset may empty the pipe
		stall_run  = 0;
		exp_q.delete();                                     // In-flight work is dropped
		edge_stall = 1'b0;
		edge_reset = 1'b1;
		repeat (cycles) begin
			@(negedge clock);
			sample_outputs();
		end
		reset      = 1'b0;
		stall      = 1'b0;
		edge_reset = 1'b0;
	endtask

	task automatic run_test(input string name, input int n, input int mode,
		input bit stall_on, input bit gaps, input bit mid_reset);
		int err0, chk0;
		err0 = errors;
		chk0 = checks;
		sent = 0;
		while (sent < n / 2)
			step(mode, stall_on, gaps);
		if (mid_reset)
			pulse_reset(3);
		while (sent < n)
			step(mode, stall_on, gaps);
		drain();
		$display("test %-14s %4d instructions %5d checks %3d errors", name, n,
			checks - chk0, errors - err0);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		reset         = 1'b1;
		stall         = 1'b0;
		id_valid      = 1'b0;
		pc            = '0;
		npc           = '0;
		inst          = '0;
		rs1_value     = '0;
		rs2_value     = '0;
		opa_select    = rv32_isa_pkg::OPA_IS_RS1;
		opb_select    = rv32_isa_pkg::OPB_IS_RS2;
		alu_func      = rv32_isa_pkg::ALU_ADD;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		dest_reg_idx  = '0;
		halt          = 1'b0;
		illegal       = 1'b0;
		edge_reset    = 1'b1;
		edge_stall    = 1'b0;
		held_snap     = '0;
		stall_run     = 0;
		errors        = 0;
		checks        = 0;
		popped        = 0;
		repeat (16) begin
			@(negedge clock);
			sample_outputs();
		end
		reset      = 1'b0;
		edge_reset = 1'b0;
		run_test("alu_reg_reg", N_ALU, MODE_ALU, 1'b0, 1'b0, 1'b0);
		run_test("operand_select", N_SEL, MODE_SEL, 1'b0, 1'b0, 1'b0);
		run_test("branch", N_BR, MODE_BR, 1'b0, 1'b0, 1'b0);
		run_test("pass_through", N_PASS, MODE_MIX, 1'b0, 1'b1, 1'b0);
		run_test("back_pressure", N_STALL, MODE_MIX, 1'b1, 1'b0, 1'b0);
		run_test("mid_reset", N_RESET, MODE_MIX, 1'b1, 1'b0, 1'b1);
		$display("%0d instructions checked, %0d checks, %0d errors", popped, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns before all tests finished", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/rv32_isa_pkg.sv
src/ex_pipe_pkg.sv
src/ex_ops_if.sv
src/ex_operand_sel.sv
src/alu.sv
src/brcond.sv
src/pipe_reg.sv
src/ex_stage.sv
verif/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = ex_stage_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
